//--- rnn_pkg.sv
`default_nettype none

package rnn_pkg;

	// Q16.16 fixed point
	localparam int FIXED_W = 32;
	localparam int FRAC_W = 16;
	localparam logic signed [FIXED_W-1:0] ONE_Q = 32'sd1 <<< FRAC_W;
	localparam logic signed [FIXED_W-1:0] HALF_Q = ONE_Q >>> 1;
	localparam logic signed [FIXED_W-1:0] MINUS_ONE_Q = -ONE_Q;

	// weights are stored pre-multiplied by 256
	localparam int WSCALE_SHIFT = 8;

	// layer sizes
	localparam int MAX_INPUTS = 16;
	localparam int MAX_NEURONS = 8;
	localparam int WEIGHT_DEPTH = MAX_INPUTS * MAX_NEURONS;
	localparam int FEAT_AW = $clog2(MAX_INPUTS);
	localparam int NEUR_AW = $clog2(MAX_NEURONS);
	localparam int WGT_AW = $clog2(WEIGHT_DEPTH);

	// tanh table, 1/256 step in x
	localparam int LUT_DEPTH = 1024;
	localparam int LUT_AW = 10;
	localparam int LUT_FRAC_W = 8;
	localparam int SAT_W = FIXED_W - LUT_AW - LUT_FRAC_W;

	// APB map, byte addresses
	localparam int APB_AW = 13;
	localparam logic [APB_AW-1:0] ADDR_CTRL = 13'h000;
	localparam logic [APB_AW-1:0] ADDR_SIZES = 13'h004;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 13'h008;
	localparam logic [APB_AW-1:0] FEAT_BASE = 13'h100;
	localparam logic [APB_AW-1:0] BIAS_BASE = 13'h200;
	localparam logic [APB_AW-1:0] OUT_BASE = 13'h300;
	localparam logic [APB_AW-1:0] WGT_BASE = 13'h400;
	localparam logic [APB_AW-1:0] LUT_BASE = 13'h1000;

	// memory write select
	localparam logic [1:0] MEM_FEAT = 2'd0;
	localparam logic [1:0] MEM_BIAS = 2'd1;
	localparam logic [1:0] MEM_WGT = 2'd2;
	localparam logic [1:0] MEM_LUT = 2'd3;

	// sequencer states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BIAS = 2'd1;
	localparam logic [1:0] ST_ACC = 2'd2;
	localparam logic [1:0] ST_DRAIN = 2'd3;

	// activation input, as a number or as table fields
	typedef union packed {
		logic signed [FIXED_W-1:0] q;
		struct packed {
			logic [SAT_W-1:0] sat;
			logic [LUT_AW-1:0] idx;
			logic [LUT_FRAC_W-1:0] frac;
		} f;
	} act_word_u;

endpackage

`default_nettype wire

//--- dense_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module dense_apb_regs (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          psel_i,
	input  wire logic                          penable_i,
	input  wire logic                          pwrite_i,
	input  wire logic [rnn_pkg::APB_AW-1:0]    paddr_i,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   pwdata_i,
	output logic [rnn_pkg::FIXED_W-1:0]        prdata_o,
	output logic                               pready_o,
	output logic                               pslverr_o,
	input  wire logic                          busy_i,
	input  wire logic                          done_i,
	output logic                               start_o,
	output logic                               act_sigmoid_o,
	output logic [rnn_pkg::FEAT_AW:0]          n_inputs_o,
	output logic [rnn_pkg::NEUR_AW:0]          n_neurons_o,
	output logic                               mem_we_o,
	output logic [1:0]                         mem_sel_o,
	output logic [rnn_pkg::LUT_AW-1:0]         mem_addr_o,
	output logic [rnn_pkg::FIXED_W-1:0]        mem_wdata_o,
	output logic [rnn_pkg::NEUR_AW-1:0]        out_raddr_o,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   out_rdata_i
);

	logic wr, rd, blocked;
	logic ctrl_hit, sizes_hit, status_hit;
	logic feat_hit, bias_hit, wgt_hit, lut_hit, out_hit, mem_hit;
	logic done_q;

	assign wr = psel_i & penable_i & pwrite_i;
	assign rd = psel_i & penable_i & ~pwrite_i;
	// start already issued counts as busy too
	assign blocked = busy_i | start_o;

	// register and window decode, word aligned
	assign ctrl_hit = (paddr_i >> 2) == (rnn_pkg::ADDR_CTRL >> 2);
	assign sizes_hit = (paddr_i >> 2) == (rnn_pkg::ADDR_SIZES >> 2);
	assign status_hit = (paddr_i >> 2) == (rnn_pkg::ADDR_STATUS >> 2);
	assign feat_hit = (paddr_i >> (rnn_pkg::FEAT_AW + 2)) ==
		(rnn_pkg::FEAT_BASE >> (rnn_pkg::FEAT_AW + 2));
	assign bias_hit = (paddr_i >> (rnn_pkg::NEUR_AW + 2)) ==
		(rnn_pkg::BIAS_BASE >> (rnn_pkg::NEUR_AW + 2));
	assign out_hit = (paddr_i >> (rnn_pkg::NEUR_AW + 2)) ==
		(rnn_pkg::OUT_BASE >> (rnn_pkg::NEUR_AW + 2));
	assign wgt_hit = (paddr_i >> (rnn_pkg::WGT_AW + 2)) ==
		(rnn_pkg::WGT_BASE >> (rnn_pkg::WGT_AW + 2));
	assign lut_hit = (paddr_i >> (rnn_pkg::LUT_AW + 2)) ==
		(rnn_pkg::LUT_BASE >> (rnn_pkg::LUT_AW + 2));
	assign mem_hit = feat_hit | bias_hit | wgt_hit | lut_hit;

	// memory writes, the low address bits index each array
	assign mem_we_o = wr & mem_hit & ~blocked;
	assign mem_addr_o = paddr_i[rnn_pkg::LUT_AW+1:2];
	assign mem_wdata_o = pwdata_i;
	assign out_raddr_o = paddr_i[rnn_pkg::NEUR_AW+1:2];

	always_comb begin
		if (lut_hit)
			mem_sel_o = rnn_pkg::MEM_LUT;
		else if (wgt_hit)
			mem_sel_o = rnn_pkg::MEM_WGT;
		else if (bias_hit)
			mem_sel_o = rnn_pkg::MEM_BIAS;
		else
			mem_sel_o = rnn_pkg::MEM_FEAT;
	end

	assign pready_o = 1'b1;
	assign pslverr_o = (wr & (mem_hit | sizes_hit) & blocked) |
		(rd & ~(ctrl_hit | sizes_hit | status_hit | out_hit));

	// output window data was addressed during setup
	always_comb begin
		prdata_o = '0;
		if (rd) begin
			if (ctrl_hit) begin
				prdata_o[1] = act_sigmoid_o;
			end else if (sizes_hit) begin
				prdata_o[rnn_pkg::FEAT_AW:0] = n_inputs_o;
				prdata_o[16 +: rnn_pkg::NEUR_AW+1] = n_neurons_o;
			end else if (status_hit) begin
				prdata_o[0] = busy_i;
				prdata_o[1] = done_q;
			end else if (out_hit) begin
				prdata_o = out_rdata_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			start_o <= 1'b0;
			act_sigmoid_o <= 1'b0;
			n_inputs_o <= '0;
			n_neurons_o <= '0;
			done_q <= 1'b0;
		end else begin
			start_o <= 1'b0;
			if (wr && ctrl_hit && !blocked) begin
				start_o <= pwdata_i[0];
				act_sigmoid_o <= pwdata_i[1];
			end
			if (wr && sizes_hit && !blocked) begin
				n_inputs_o <= pwdata_i[rnn_pkg::FEAT_AW:0];
				n_neurons_o <= pwdata_i[16 +: rnn_pkg::NEUR_AW+1];
			end
			// sticky until the next run starts
			if (start_o)
				done_q <= 1'b0;
			else if (done_i)
				done_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- layer_mem.sv
`timescale 1ns/1ns
`default_nettype none

module layer_mem (
	input  wire logic                          clk,
	input  wire logic                          mem_we_i,
	input  wire logic [1:0]                    mem_sel_i,
	input  wire logic [rnn_pkg::LUT_AW-1:0]    mem_addr_i,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   mem_wdata_i,
	input  wire logic [rnn_pkg::FEAT_AW-1:0]   feat_raddr_i,
	output logic [rnn_pkg::FIXED_W-1:0]        feat_rdata_o,
	input  wire logic [rnn_pkg::NEUR_AW-1:0]   bias_raddr_i,
	output logic [rnn_pkg::FIXED_W-1:0]        bias_rdata_o,
	input  wire logic [rnn_pkg::WGT_AW-1:0]    wgt_raddr_i,
	output logic [rnn_pkg::FIXED_W-1:0]        wgt_rdata_o,
	input  wire logic [rnn_pkg::LUT_AW-1:0]    lut_raddr_i,
	output logic [rnn_pkg::FIXED_W-1:0]        lut_rdata_o,
	output logic [rnn_pkg::FIXED_W-1:0]        lut_next_rdata_o,
	input  wire logic                          res_we_i,
	input  wire logic [rnn_pkg::NEUR_AW-1:0]   res_addr_i,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   res_data_i,
	input  wire logic [rnn_pkg::NEUR_AW-1:0]   out_raddr_i,
	output logic [rnn_pkg::FIXED_W-1:0]        out_rdata_o
);

	logic [rnn_pkg::FIXED_W-1:0] feat_mem [rnn_pkg::MAX_INPUTS];
	logic [rnn_pkg::FIXED_W-1:0] bias_mem [rnn_pkg::MAX_NEURONS];
	logic [rnn_pkg::FIXED_W-1:0] wgt_mem [rnn_pkg::WEIGHT_DEPTH];
	logic [rnn_pkg::FIXED_W-1:0] lut_mem [rnn_pkg::LUT_DEPTH];
	logic [rnn_pkg::FIXED_W-1:0] out_mem [rnn_pkg::MAX_NEURONS];

	logic [rnn_pkg::LUT_AW-1:0] lut_next_addr;

	// upper neighbour for interpolation, held at the last entry
	assign lut_next_addr = (lut_raddr_i == rnn_pkg::LUT_DEPTH - 1) ?
		lut_raddr_i : lut_raddr_i + 1'b1;

	// host writes
	always_ff @(posedge clk) begin
		if (mem_we_i) begin
			case (mem_sel_i)
				rnn_pkg::MEM_FEAT:
					feat_mem[mem_addr_i[rnn_pkg::FEAT_AW-1:0]] <= mem_wdata_i;
				rnn_pkg::MEM_BIAS:
					bias_mem[mem_addr_i[rnn_pkg::NEUR_AW-1:0]] <= mem_wdata_i;
				rnn_pkg::MEM_WGT:
					wgt_mem[mem_addr_i[rnn_pkg::WGT_AW-1:0]] <= mem_wdata_i;
				default:
					lut_mem[mem_addr_i] <= mem_wdata_i;
			endcase
		end
	end

	// activation results
	always_ff @(posedge clk) begin
		if (res_we_i)
			out_mem[res_addr_i] <= res_data_i;
	end

	// one registered read port per consumer
	always_ff @(posedge clk) begin
		feat_rdata_o <= feat_mem[feat_raddr_i];
		bias_rdata_o <= bias_mem[bias_raddr_i];
		wgt_rdata_o <= wgt_mem[wgt_raddr_i];
		lut_rdata_o <= lut_mem[lut_raddr_i];
		lut_next_rdata_o <= lut_mem[lut_next_addr];
		out_rdata_o <= out_mem[out_raddr_i];
	end

endmodule

`default_nettype wire

//--- mac_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module mac_sequencer (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          start_i,
	input  wire logic [rnn_pkg::FEAT_AW:0]     n_inputs_i,
	input  wire logic [rnn_pkg::NEUR_AW:0]     n_neurons_i,
	output logic [rnn_pkg::FEAT_AW-1:0]        feat_raddr_o,
	output logic [rnn_pkg::NEUR_AW-1:0]        bias_raddr_o,
	output logic [rnn_pkg::WGT_AW-1:0]         wgt_raddr_o,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   feat_rdata_i,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   bias_rdata_i,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   wgt_rdata_i,
	output logic                               sum_valid_o,
	output logic [rnn_pkg::FIXED_W-1:0]        sum_o,
	output logic [rnn_pkg::NEUR_AW-1:0]        sum_neuron_o,
	input  wire logic                          res_valid_i,
	output logic                               busy_o,
	output logic                               done_o
);

	logic [1:0] state;
	logic [rnn_pkg::NEUR_AW-1:0] neuron;
	logic [rnn_pkg::FEAT_AW-1:0] inp, rd_inp;
	logic first;
	logic [rnn_pkg::FEAT_AW+rnn_pkg::NEUR_AW:0] wgt_idx;
	logic signed [2*rnn_pkg::FIXED_W-1:0] prod;
	logic signed [rnn_pkg::FIXED_W-1:0] prod_mid, acc_base, acc;
	logic last_inp, last_neuron;
	logic [rnn_pkg::NEUR_AW:0] sum_cnt, res_cnt;

	// addresses run one input ahead of the data
	always_comb begin
		rd_inp = (state == rnn_pkg::ST_BIAS) ? '0 : inp + 1'b1;
		wgt_idx = rd_inp * n_neurons_i + neuron;
	end

	assign feat_raddr_o = rd_inp;
	assign bias_raddr_o = neuron;
	assign wgt_raddr_o = wgt_idx[rnn_pkg::WGT_AW-1:0];

	// Q16.16 product keeps the middle word
	assign prod = $signed(feat_rdata_i) * $signed(wgt_rdata_i);
	assign prod_mid = prod[rnn_pkg::FIXED_W+rnn_pkg::FRAC_W-1:rnn_pkg::FRAC_W];
	assign acc_base = first ? $signed(bias_rdata_i) : acc;

	assign last_inp = ({1'b0, inp} + 1'b1) >= n_inputs_i;
	assign last_neuron = ({1'b0, neuron} + 1'b1) >= n_neurons_i;

	// acc is stable while the next bias is fetched
	assign sum_o = acc;

	always_ff @(posedge clk) begin
		if (state == rnn_pkg::ST_ACC)
			acc <= acc_base + prod_mid;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rnn_pkg::ST_IDLE;
			neuron <= '0;
			inp <= '0;
			first <= 1'b0;
			sum_valid_o <= 1'b0;
			sum_neuron_o <= '0;
			sum_cnt <= '0;
			res_cnt <= '0;
			busy_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			sum_valid_o <= 1'b0;
			done_o <= 1'b0;
			if (res_valid_i)
				res_cnt <= res_cnt + 1'b1;
			case (state)
				rnn_pkg::ST_IDLE: begin
					if (start_i) begin
						state <= rnn_pkg::ST_BIAS;
						neuron <= '0;
						sum_cnt <= '0;
						res_cnt <= '0;
						busy_o <= 1'b1;
					end
				end
				rnn_pkg::ST_BIAS: begin
					state <= rnn_pkg::ST_ACC;
					inp <= '0;
					first <= 1'b1;
				end
				rnn_pkg::ST_ACC: begin
					first <= 1'b0;
					if (last_inp) begin
						sum_valid_o <= 1'b1;
						sum_neuron_o <= neuron;
						sum_cnt <= sum_cnt + 1'b1;
						if (last_neuron) begin
							state <= rnn_pkg::ST_DRAIN;
						end else begin
							neuron <= neuron + 1'b1;
							state <= rnn_pkg::ST_BIAS;
						end
					end else begin
						inp <= inp + 1'b1;
					end
				end
				default: begin
					// wait for the activation pipe to empty
					if (res_cnt == sum_cnt) begin
						state <= rnn_pkg::ST_IDLE;
						busy_o <= 1'b0;
						done_o <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- activation_unit.sv
`timescale 1ns/1ns
`default_nettype none

module activation_unit (
	input  wire logic                                 clk,
	input  wire logic                                 rst,
	input  wire logic                                 sum_valid_i,
	input  wire logic signed [rnn_pkg::FIXED_W-1:0]   sum_i,
	input  wire logic [rnn_pkg::NEUR_AW-1:0]          sum_neuron_i,
	input  wire logic                                 act_sigmoid_i,
	output logic [rnn_pkg::LUT_AW-1:0]                lut_raddr_o,
	input  wire logic [rnn_pkg::FIXED_W-1:0]          lut_rdata_i,
	input  wire logic [rnn_pkg::FIXED_W-1:0]          lut_next_rdata_i,
	output logic                                      res_valid_o,
	output logic [rnn_pkg::FIXED_W-1:0]               res_data_o,
	output logic [rnn_pkg::NEUR_AW-1:0]               res_neuron_o
);

	logic signed [rnn_pkg::FIXED_W-1:0] scaled;
	rnn_pkg::act_word_u mag_in, s1_word;
	logic s1_valid, s1_neg, s1_sig;
	logic [rnn_pkg::NEUR_AW-1:0] s1_neuron;
	logic signed [rnn_pkg::FIXED_W:0] diff;
	logic signed [rnn_pkg::FIXED_W+rnn_pkg::LUT_FRAC_W+1:0] step, step_sh;
	logic signed [rnn_pkg::FIXED_W-1:0] interp, tanh_v, act_v;

	// stage one: weight scale, extra halving for sigmoid, magnitude
	always_comb begin
		if (act_sigmoid_i)
			scaled = sum_i >>> (rnn_pkg::WSCALE_SHIFT + 1);
		else
			scaled = sum_i >>> rnn_pkg::WSCALE_SHIFT;
		mag_in.q = scaled[rnn_pkg::FIXED_W-1] ? -scaled : scaled;
	end

	// table read lands together with the stage one registers
	assign lut_raddr_o = mag_in.f.idx;

	always_ff @(posedge clk) begin
		s1_word <= mag_in;
		s1_neg <= scaled[rnn_pkg::FIXED_W-1];
		s1_sig <= act_sigmoid_i;
		s1_neuron <= sum_neuron_i;
	end

	// stage two: linear interpolation between neighbours
	always_comb begin
		diff = $signed({lut_next_rdata_i[rnn_pkg::FIXED_W-1], lut_next_rdata_i}) -
			$signed({lut_rdata_i[rnn_pkg::FIXED_W-1], lut_rdata_i});
		step = diff * $signed({1'b0, s1_word.f.frac});
		step_sh = step >>> rnn_pkg::LUT_FRAC_W;
		interp = $signed(lut_rdata_i) + step_sh[rnn_pkg::FIXED_W-1:0];
		// beyond the table tanh is flat at +-1
		if (s1_word.f.sat != '0)
			tanh_v = s1_neg ? rnn_pkg::MINUS_ONE_Q : rnn_pkg::ONE_Q;
		else
			tanh_v = s1_neg ? -interp : interp;
		// sigmoid(x) = tanh(x/2)/2 + 1/2
		act_v = s1_sig ? (tanh_v >>> 1) + rnn_pkg::HALF_Q : tanh_v;
	end

	always_ff @(posedge clk) begin
		res_data_o <= act_v;
		res_neuron_o <= s1_neuron;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			res_valid_o <= 1'b0;
		end else begin
			s1_valid <= sum_valid_i;
			res_valid_o <= s1_valid;
		end
	end

endmodule

`default_nettype wire

//--- dense_layer_top.sv
`timescale 1ns/1ns
`default_nettype none

module dense_layer_top (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          psel_i,
	input  wire logic                          penable_i,
	input  wire logic                          pwrite_i,
	input  wire logic [rnn_pkg::APB_AW-1:0]    paddr_i,
	input  wire logic [rnn_pkg::FIXED_W-1:0]   pwdata_i,
	output logic [rnn_pkg::FIXED_W-1:0]        prdata_o,
	output logic                               pready_o,
	output logic                               pslverr_o,
	output logic                               done_o
);

	logic start, act_sigmoid, busy;
	logic [rnn_pkg::FEAT_AW:0] n_inputs;
	logic [rnn_pkg::NEUR_AW:0] n_neurons;
	logic mem_we;
	logic [1:0] mem_sel;
	logic [rnn_pkg::LUT_AW-1:0] mem_addr, lut_raddr;
	logic [rnn_pkg::FIXED_W-1:0] mem_wdata, out_rdata;
	logic [rnn_pkg::NEUR_AW-1:0] out_raddr, bias_raddr, sum_neuron, res_neuron;
	logic [rnn_pkg::FEAT_AW-1:0] feat_raddr;
	logic [rnn_pkg::WGT_AW-1:0] wgt_raddr;
	logic [rnn_pkg::FIXED_W-1:0] feat_rdata, bias_rdata, wgt_rdata;
	logic [rnn_pkg::FIXED_W-1:0] lut_rdata, lut_next_rdata, sum, res_data;
	logic sum_valid, res_valid;

	dense_apb_regs regs0 (
		.clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i),
		.pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
		.busy_i(busy), .done_i(done_o), .start_o(start), .act_sigmoid_o(act_sigmoid),
		.n_inputs_o(n_inputs), .n_neurons_o(n_neurons), .mem_we_o(mem_we),
		.mem_sel_o(mem_sel), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
		.out_raddr_o(out_raddr), .out_rdata_i(out_rdata)
	);

	layer_mem mem0 (
		.clk(clk), .mem_we_i(mem_we), .mem_sel_i(mem_sel), .mem_addr_i(mem_addr),
		.mem_wdata_i(mem_wdata), .feat_raddr_i(feat_raddr), .feat_rdata_o(feat_rdata),
		.bias_raddr_i(bias_raddr), .bias_rdata_o(bias_rdata), .wgt_raddr_i(wgt_raddr),
		.wgt_rdata_o(wgt_rdata), .lut_raddr_i(lut_raddr), .lut_rdata_o(lut_rdata),
		.lut_next_rdata_o(lut_next_rdata), .res_we_i(res_valid), .res_addr_i(res_neuron),
		.res_data_i(res_data), .out_raddr_i(out_raddr), .out_rdata_o(out_rdata)
	);

	mac_sequencer seq0 (
		.clk(clk), .rst(rst), .start_i(start), .n_inputs_i(n_inputs),
		.n_neurons_i(n_neurons), .feat_raddr_o(feat_raddr), .bias_raddr_o(bias_raddr),
		.wgt_raddr_o(wgt_raddr), .feat_rdata_i(feat_rdata), .bias_rdata_i(bias_rdata),
		.wgt_rdata_i(wgt_rdata), .sum_valid_o(sum_valid), .sum_o(sum),
		.sum_neuron_o(sum_neuron), .res_valid_i(res_valid), .busy_o(busy), .done_o(done_o)
	);

	activation_unit act0 (
		.clk(clk), .rst(rst), .sum_valid_i(sum_valid), .sum_i(sum),
		.sum_neuron_i(sum_neuron), .act_sigmoid_i(act_sigmoid), .lut_raddr_o(lut_raddr),
		.lut_rdata_i(lut_rdata), .lut_next_rdata_i(lut_next_rdata),
		.res_valid_o(res_valid), .res_data_o(res_data), .res_neuron_o(res_neuron)
	);

endmodule

`default_nettype wire

//--- dense_layer_props.sv
`timescale 1ns/1ns
`default_nettype none

module dense_layer_props (
	input wire logic clk,
	input wire logic rst,
	input wire logic psel_i,
	input wire logic penable_i,
	input wire logic pready_i,
	input wire logic pslverr_i,
	input wire logic start_i,
	input wire logic done_i
);

	int fail_cnt = 0;
	logic run_open;

	// open from start until the matching done pulse
	always_ff @(posedge clk) begin
		if (rst)
			run_open <= 1'b0;
		else if (start_i)
			run_open <= 1'b1;
		else if (done_i)
			run_open <= 1'b0;
	end

	done_one_cycle: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
		else begin
			$error("done_o stayed high for more than one cycle");
			fail_cnt++;
		end

	pready_high: assert property (@(posedge clk) pready_i)
		else begin
			$error("pready_o went low");
			fail_cnt++;
		end

	// error response only while a transfer is in its access phase
	pslverr_access: assert property (@(posedge clk) disable iff (rst)
		pslverr_i |-> psel_i && penable_i)
		else begin
			$error("pslverr_o high outside an access phase");
			fail_cnt++;
		end

	done_after_start: assert property (@(posedge clk) disable iff (rst) done_i |-> run_open)
		else begin
			$error("done pulse without an earlier start");
			fail_cnt++;
		end

endmodule

bind dense_layer_top dense_layer_props props0 (
	.clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i),
	.pready_i(pready_o), .pslverr_i(pslverr_o), .start_i(start), .done_i(done_o)
);

`default_nettype wire

//--- dense_layer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dense_layer_tb;

	localparam int CLK_PERIOD = 100;
	localparam int QTR = CLK_PERIOD / 4;
	localparam int RUN_TIMEOUT = 1000;

	logic clk, rst, psel, penable, pwrite, pready, pslverr, done;
	logic [rnn_pkg::APB_AW-1:0] paddr;
	logic [31:0] pwdata, prdata;
	int mismatches, failures;

	// host-side copy of what was loaded
	logic signed [31:0] feat_m [rnn_pkg::MAX_INPUTS];
	logic signed [31:0] bias_m [rnn_pkg::MAX_NEURONS];
	logic signed [31:0] wgt_m [rnn_pkg::WEIGHT_DEPTH];
	logic signed [31:0] lut_m [rnn_pkg::LUT_DEPTH];
	int n_in_m, n_neu_m;

	dense_layer_top dut0 (
		.clk(clk), .rst(rst), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
		.pslverr_o(pslverr), .done_o(done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic int rand_sym(input int lim);
		return int'($urandom % (2 * lim + 1)) - lim;
	endfunction

	// expected neuron output from the layer rules
	function automatic logic [31:0] model_out(input int j, input bit sig);
		logic signed [31:0] acc, sc, y;
		logic signed [63:0] p;
		rnn_pkg::act_word_u w;
		int i, cur, nxt, fr;
		acc = bias_m[j];
		for (i = 0; i < n_in_m; i++) begin
			p = feat_m[i] * wgt_m[i * n_neu_m + j];
			acc = acc + p[47:16];
		end
		// weight scale and the halving for sigmoid
		sc = sig ? acc >>> 9 : acc >>> 8;
		w.q = (sc < 0) ? -sc : sc;
		cur = lut_m[w.f.idx];
		nxt = lut_m[(w.f.idx == 10'd1023) ? 1023 : w.f.idx + 1];
		fr = w.f.frac;
		y = cur + (((nxt - cur) * fr) >>> 8);
		if (w.f.sat != 0)
			y = rnn_pkg::ONE_Q;
		if (sc < 0)
			y = -y;
		if (sig)
			y = (y >>> 1) + rnn_pkg::HALF_Q;
		return y;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			mismatches++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic apb_xfer(input bit wr, input logic [12:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output bit err);
		int n;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(QTR);
		n = 0;
		while (!pready && n < 16) begin
			@(negedge clk);
			#(QTR);
			n++;
		end
		if (!pready) begin
			failures++;
			$display("APB transfer to %h never got pready", addr);
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [12:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bit err;
		apb_xfer(1'b1, addr, data, unused, err);
		assert (!err) else begin
			failures++;
			$display("write to %h got an error response", addr);
		end
	endtask

	task automatic read_reg(input logic [12:0] addr, output logic [31:0] data);
		bit err;
		apb_xfer(1'b0, addr, 32'h0, data, err);
		assert (!err) else begin
			failures++;
			$display("read of %h got an error response", addr);
		end
	endtask

	task automatic fill_layer(input int n_in, input int n_neu, input int flim, input int wlim,
			input int blim, input bit sat);
		int i, j;
		n_in_m = n_in;
		n_neu_m = n_neu;
		write_reg(rnn_pkg::ADDR_SIZES, 32'(n_in) | (32'(n_neu) << 16));
		for (i = 0; i < n_in; i++) begin
			feat_m[i] = rand_sym(flim);
			write_reg(rnn_pkg::FEAT_BASE + 13'(4 * i), feat_m[i]);
		end
		// saturation runs push the bias far past 4.0 with alternating sign
		for (j = 0; j < n_neu; j++) begin
			bias_m[j] = rand_sym(blim) + (sat ? ((j % 2) ? -(2 ** 28) : 2 ** 28) : 0);
			write_reg(rnn_pkg::BIAS_BASE + 13'(4 * j), bias_m[j]);
		end
		for (i = 0; i < n_in * n_neu; i++) begin
			wgt_m[i] = rand_sym(wlim);
			write_reg(rnn_pkg::WGT_BASE + 13'(4 * i), wgt_m[i]);
		end
	endtask

	task automatic start_run(input bit sig);
		write_reg(rnn_pkg::ADDR_CTRL, {30'b0, sig, 1'b1});
	endtask

	task automatic wait_done(input string name);
		int n;
		n = 0;
		while (!done && n < RUN_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			failures++;
			$display("%s: done never came", name);
		end
	endtask

	task automatic check_outputs(input string name, input bit sig);
		logic [31:0] rd;
		int j;
		for (j = 0; j < n_neu_m; j++) begin
			read_reg(rnn_pkg::OUT_BASE + 13'(4 * j), rd);
			check_value($sformatf("%s neuron %0d", name, j), model_out(j, sig), rd);
			if (sig) begin
				assert ($signed(rd) >= 0 && $signed(rd) <= rnn_pkg::ONE_Q) else begin
					failures++;
					$display("%s neuron %0d: sigmoid output %h outside 0 to 1",
						name, j, rd);
				end
			end
		end
	endtask

	initial begin
		logic [31:0] rd;
		bit err;
		int k;
		void'($urandom(32'ha056d333));
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		mismatches = 0;
		failures = 0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		read_reg(rnn_pkg::ADDR_STATUS, rd);
		check_value("reset status", 32'h0, rd);
		write_reg(rnn_pkg::ADDR_SIZES, 32'h0003_0005);
		read_reg(rnn_pkg::ADDR_SIZES, rd);
		check_value("sizes readback", 32'h0003_0005, rd);

		// linear table makes tanh the identity below 4.0
		for (k = 0; k < rnn_pkg::LUT_DEPTH; k++) begin
			lut_m[k] = k * 256;
			write_reg(rnn_pkg::LUT_BASE + 13'(4 * k), lut_m[k]);
		end

		fill_layer(5, 3, 2 ** 17, 2 ** 20, 2 ** 20, 1'b0);
		start_run(1'b0);
		wait_done("tanh");
		check_outputs("tanh", 1'b0);

		start_run(1'b1);
		wait_done("sigmoid");
		check_outputs("sigmoid", 1'b1);

		fill_layer(5, 3, 2 ** 12, 2 ** 12, 2 ** 20, 1'b1);
		start_run(1'b0);
		wait_done("saturation");
		for (k = 0; k < 3; k++) begin
			read_reg(rnn_pkg::OUT_BASE + 13'(4 * k), rd);
			check_value($sformatf("saturation neuron %0d", k),
				(k % 2) ? rnn_pkg::MINUS_ONE_Q : rnn_pkg::ONE_Q, rd);
		end

		// weight write while the engine runs must be refused
		fill_layer(5, 3, 2 ** 17, 2 ** 20, 2 ** 20, 1'b0);
		start_run(1'b0);
		apb_xfer(1'b1, rnn_pkg::WGT_BASE, 32'h7fff_ffff, rd, err);
		assert (err) else begin
			failures++;
			$display("weight write during busy was not refused");
		end
		wait_done("busy write");
		// the next run reads weight 0 again
		start_run(1'b0);
		wait_done("busy write rerun");
		check_outputs("busy write rerun", 1'b0);

		fill_layer(16, 8, 2 ** 17, 2 ** 20, 2 ** 20, 1'b0);
		start_run(1'b0);
		read_reg(rnn_pkg::ADDR_STATUS, rd);
		check_value("second start status", 32'h1, rd);
		wait_done("full size");
		check_outputs("full size", 1'b0);

		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, dut0.props0.fail_cnt);
		if (mismatches + failures + dut0.props0.fail_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rnn_pkg.sv
dense_apb_regs.sv
layer_mem.sv
mac_sequencer.sv
activation_unit.sv
dense_layer_top.sv
dense_layer_props.sv
dense_layer_tb.sv

//--- Bender.yml
package:
  name: dense_layer

sources:
  - rnn_pkg.sv
  - dense_apb_regs.sv
  - layer_mem.sv
  - mac_sequencer.sv
  - activation_unit.sv
  - dense_layer_top.sv
  - target: test
    files:
      - dense_layer_props.sv
      - dense_layer_tb.sv
